//--- rv_core_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I core types
// Opcodes, ALU ops, access sizes, branch kinds and pipeline structs
//////////////////////////////////////////////////////////////////////
package rv_core_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA
  } alu_op_t;

  // Encoded as funct3, stores reuse LB/LH/LW for SB/SH/SW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } mem_size_t;

  typedef enum logic [2:0] {
    BEQ = 3'b000,
    BNE = 3'b001,
    BLT = 3'b100,
    BGE = 3'b101
  } branch_t;

  // Write-back source select
  localparam logic [1:0] W_LOAD = 2'd0;
  localparam logic [1:0] W_PC4  = 2'd1;
  localparam logic [1:0] W_UIMM = 2'd2;
  localparam logic [1:0] W_ALU  = 2'd3;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       alu_b_sel;   // 1 selects the immediate
    logic [1:0] w_sel;
    logic       wen;
    logic       dren;
    logic       dwen;
    mem_size_t  mem_size;
    logic       branch;
    branch_t    branch_type;
    logic       jump;
    logic       j_sel;       // 1 for JAL, 0 for JALR
    logic       halt;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    word_t      imm;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_ex_t;

endpackage

//--- rv_mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared RAM bus types
// Request and response structs and the arbiter source encoding
//////////////////////////////////////////////////////////////////////
package rv_mem_pkg;

  // Held by a requester until its grant
  typedef struct packed {
    logic        ren;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;
  } mem_req_t;

  // rvalid pulses one cycle after a granted read
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } mem_resp_t;

  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_EXEC,
    SRC_FETCH,
    SRC_HOST
  } mem_src_t;

endpackage

//--- control_unit.sv
//////////////////////////////////////////////////////////////////////
// Control unit
// Decodes one RV32I word into control fields and an extended immediate
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module control_unit (
  input  rv_core_pkg::word_t instr,
  output rv_core_pkg::ctrl_t ctrl
);
  import rv_core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  // Immediates per format, all sign-extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl             = '0;
    ctrl.alu_op      = ADD;
    ctrl.w_sel       = W_ALU;
    // funct3 doubles as access size and branch kind
    ctrl.mem_size    = mem_size_t'(funct3);
    ctrl.branch_type = branch_t'(funct3);
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];

    case (opcode)
      OP: begin
        ctrl.wen = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = funct7_b5 ? SUB : ADD;
          3'b001:  ctrl.alu_op = SLL;
          3'b010:  ctrl.alu_op = SLT;
          3'b100:  ctrl.alu_op = XOR;
          3'b101:  ctrl.alu_op = funct7_b5 ? SRA : SRL;
          3'b110:  ctrl.alu_op = OR;
          3'b111:  ctrl.alu_op = AND;
          default: ctrl.alu_op = ADD;
        endcase
      end
      // ADDI only
      OP_IMM: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_i;
      end
      LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = W_UIMM;
        ctrl.imm   = imm_u;
      end
      LOAD: begin
        ctrl.wen       = 1'b1;
        ctrl.dren      = 1'b1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.w_sel     = W_LOAD;
        ctrl.imm       = imm_i;
      end
      STORE: begin
        ctrl.dwen      = 1'b1;
        ctrl.alu_b_sel = 1'b1;
        ctrl.imm       = imm_s;
      end
      BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.imm    = imm_b;
      end
      JAL: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.wen   = 1'b1;
        ctrl.w_sel = W_PC4;
        ctrl.imm   = imm_j;
      end
      JALR: begin
        ctrl.jump  = 1'b1;
        ctrl.wen   = 1'b1;
        ctrl.w_sel = W_PC4;
        ctrl.imm   = imm_i;
      end
      // ECALL stops the core
      SYSTEM: ctrl.halt = (funct3 == 3'b000);
      default: ctrl.wen = 1'b0;
    endcase
  end

endmodule

//--- rv_reg_file.sv
//////////////////////////////////////////////////////////////////////
// Register file
// 32 x 32 bits, two combinational reads, one clocked write, x0 is zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_reg_file (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic [4:0]         rs1,
  input  logic [4:0]         rs2,
  output rv_core_pkg::word_t rs1_data,
  output rv_core_pkg::word_t rs2_data,
  input  logic               wen,
  input  logic [4:0]         rd,
  input  rv_core_pkg::word_t w_data
);
  import rv_core_pkg::*;

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= w_data;
    end
  end

  // x0 forced to zero on the read side as well
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- fetch_stage.sv
//////////////////////////////////////////////////////////////////////
// Fetch stage
// Holds the PC, reads instruction words over the shared RAM port
// and fills the fetch-to-execute register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch_stage #(
  parameter rv_core_pkg::word_t RESET_PC = '0
) (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   run,
  output rv_mem_pkg::mem_req_t   f_req,
  input  logic                   f_gnt,
  input  rv_mem_pkg::mem_resp_t  f_resp,
  input  logic                   ex_stall,
  input  logic                   brj_taken,
  input  rv_core_pkg::word_t     brj_addr,
  input  logic                   halt,
  output rv_core_pkg::fetch_ex_t fetch_ex
);
  import rv_core_pkg::*;

  word_t pc;
  word_t pc_plus4;
  logic  f_pending;
  logic  fetch_en;

  assign pc_plus4 = pc + 32'd4;

  // One read in flight at a time, none in a redirect cycle
  assign fetch_en = run & ~halt & ~ex_stall & ~brj_taken & ~f_pending;

  always_comb begin
    f_req         = '0;
    f_req.ren     = fetch_en;
    f_req.addr    = pc;
    f_req.byte_en = 4'hf;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc             <= RESET_PC;
      f_pending      <= 1'b0;
      fetch_ex.valid <= 1'b0;
    end else begin
      // Read data always lands the cycle after the grant
      if (f_req.ren && f_gnt) begin
        f_pending <= 1'b1;
      end else if (f_resp.rvalid) begin
        f_pending <= 1'b0;
      end

      if (brj_taken) begin
        // Redirect, a response landing now belongs to the old path
        pc             <= brj_addr;
        fetch_ex.valid <= 1'b0;
      end else if (f_resp.rvalid) begin
        fetch_ex <= '{valid: 1'b1, instr: f_resp.rdata, pc: pc, pc4: pc_plus4};
        pc       <= pc_plus4;
      end else if (!ex_stall) begin
        // Word consumed by execute
        fetch_ex.valid <= 1'b0;
      end
    end
  end

endmodule

//--- execute_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage
// Decode, register read, ALU, branch and jump resolution, data memory
// access with byte lanes, load extension and write-back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module execute_stage (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  rv_core_pkg::fetch_ex_t fetch_ex,
  output rv_mem_pkg::mem_req_t   d_req,
  input  logic                   d_gnt,
  input  rv_mem_pkg::mem_resp_t  d_resp,
  output logic                   brj_taken,
  output rv_core_pkg::word_t     brj_addr,
  output logic                   ex_stall,
  output logic                   halt
);
  import rv_core_pkg::*;

  ctrl_t      ctrl;
  word_t      rs1_data, rs2_data, w_data;
  word_t      alu_b, alu_out, lane, load_ext;
  logic       exec_valid, br_cond, rf_wen, d_pending;
  logic [1:0] byte_off;
  logic [3:0] byte_en;

  control_unit cu0 (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  rv_reg_file rf0 (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (ctrl.rd),
    .w_data   (w_data)
  );

  // Nothing retires once halted
  assign exec_valid = fetch_ex.valid & ~halt;

  assign alu_b = ctrl.alu_b_sel ? ctrl.imm : rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      SUB:     alu_out = rs1_data - alu_b;
      AND:     alu_out = rs1_data & alu_b;
      OR:      alu_out = rs1_data | alu_b;
      XOR:     alu_out = rs1_data ^ alu_b;
      SLT:     alu_out = {31'b0, $signed(rs1_data) < $signed(alu_b)};
      SLL:     alu_out = rs1_data << alu_b[4:0];
      SRL:     alu_out = rs1_data >> alu_b[4:0];
      SRA:     alu_out = $signed(rs1_data) >>> alu_b[4:0];
      default: alu_out = rs1_data + alu_b;
    endcase
  end

  always_comb begin
    case (ctrl.branch_type)
      BEQ:     br_cond = (rs1_data == rs2_data);
      BNE:     br_cond = (rs1_data != rs2_data);
      BLT:     br_cond = $signed(rs1_data) < $signed(rs2_data);
      BGE:     br_cond = $signed(rs1_data) >= $signed(rs2_data);
      default: br_cond = 1'b0;
    endcase
  end

  // Not-taken is the fetch default, so only taken paths redirect
  assign brj_taken = exec_valid & ((ctrl.branch & br_cond) | ctrl.jump);
  // JALR target is rs1 based with bit 0 cleared, others are pc relative
  assign brj_addr  = (ctrl.jump && !ctrl.j_sel) ? ((rs1_data + ctrl.imm) & ~32'h1)
                                                : (fetch_ex.pc + ctrl.imm);

  // Byte lanes from access size and low address bits
  assign byte_off = alu_out[1:0];
  always_comb begin
    case (ctrl.mem_size)
      LB, LBU: byte_en = 4'b0001 << byte_off;
      LH, LHU: byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
      default: byte_en = 4'b1111;
    endcase
  end

  always_comb begin
    d_req         = '0;
    d_req.ren     = exec_valid & ctrl.dren & ~d_pending;
    d_req.wen     = exec_valid & ctrl.dwen;
    d_req.addr    = alu_out;
    d_req.byte_en = byte_en;
    // Store data copied onto every lane, byte_en picks the live one
    case (ctrl.mem_size)
      LB:      d_req.wdata = {4{rs2_data[7:0]}};
      LH:      d_req.wdata = {2{rs2_data[15:0]}};
      default: d_req.wdata = rs2_data;
    endcase
  end

  // Addressed byte or half moved down to bit 0
  assign lane = d_resp.rdata >> {byte_off, 3'b000};
  always_comb begin
    case (ctrl.mem_size)
      LB:      load_ext = {{24{lane[7]}}, lane[7:0]};
      LBU:     load_ext = {24'b0, lane[7:0]};
      LH:      load_ext = {{16{lane[15]}}, lane[15:0]};
      LHU:     load_ext = {16'b0, lane[15:0]};
      default: load_ext = d_resp.rdata;
    endcase
  end

  always_comb begin
    case (ctrl.w_sel)
      W_LOAD:  w_data = load_ext;
      W_PC4:   w_data = fetch_ex.pc4;
      W_UIMM:  w_data = ctrl.imm;
      default: w_data = alu_out;
    endcase
  end

  // Store waits for grant, load waits for its read data
  assign ex_stall = exec_valid & ((ctrl.dwen & ~d_gnt) | (ctrl.dren & ~d_resp.rvalid));
  assign rf_wen   = exec_valid & ctrl.wen & ~ex_stall;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      d_pending <= 1'b0;
      halt      <= 1'b0;
    end else begin
      // Load read outstanding, blocks a repeat request
      if (d_req.ren && d_gnt) begin
        d_pending <= 1'b1;
      end else if (d_resp.rvalid) begin
        d_pending <= 1'b0;
      end
      if (exec_valid && ctrl.halt) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

//--- mem_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Memory arbiter
// Fixed priority execute, fetch, host onto one RAM port, with read
// data steered back to the requester that issued the read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  rv_mem_pkg::mem_req_t  d_req,
  input  rv_mem_pkg::mem_req_t  f_req,
  input  rv_mem_pkg::mem_req_t  host_req,
  output logic                  d_gnt,
  output logic                  f_gnt,
  output logic                  host_gnt,
  output rv_mem_pkg::mem_resp_t d_resp,
  output rv_mem_pkg::mem_resp_t f_resp,
  output rv_mem_pkg::mem_resp_t host_resp,
  output rv_mem_pkg::mem_req_t  ram_req,
  input  rv_mem_pkg::mem_resp_t ram_resp
);
  import rv_mem_pkg::*;

  mem_src_t gnt_src, src_q;

  // Kept as separate terms so a grant depends only on higher requesters
  assign d_gnt    = d_req.ren | d_req.wen;
  assign f_gnt    = (f_req.ren | f_req.wen) & ~d_gnt;
  assign host_gnt = (host_req.ren | host_req.wen) & ~d_gnt & ~f_gnt;

  always_comb begin
    ram_req = '0;
    gnt_src = SRC_NONE;
    if (d_gnt) begin
      ram_req = d_req;
      gnt_src = SRC_EXEC;
    end else if (f_gnt) begin
      ram_req = f_req;
      gnt_src = SRC_FETCH;
    end else if (host_gnt) begin
      ram_req = host_req;
      gnt_src = SRC_HOST;
    end
  end

  // Owner of the read whose data comes back next cycle
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      src_q <= SRC_NONE;
    end else begin
      src_q <= ram_req.ren ? gnt_src : SRC_NONE;
    end
  end

  always_comb begin
    d_resp           = ram_resp;
    f_resp           = ram_resp;
    host_resp        = ram_resp;
    d_resp.rvalid    = ram_resp.rvalid & (src_q == SRC_EXEC);
    f_resp.rvalid    = ram_resp.rvalid & (src_q == SRC_FETCH);
    host_resp.rvalid = ram_resp.rvalid & (src_q == SRC_HOST);
  end

endmodule

//--- unified_ram.sv
//////////////////////////////////////////////////////////////////////
// Unified RAM
// Single-port word storage with byte-enable writes and registered reads
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module unified_ram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                  CLK,
  input  rv_mem_pkg::mem_req_t  ram_req,
  output rv_mem_pkg::mem_resp_t ram_resp
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] idx;

  // Byte address, the two low bits select a lane only
  assign idx = ram_req.addr[AW+1:2];

  always_ff @(posedge CLK) begin
    if (ram_req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_req.byte_en[i]) begin
          mem[idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
        end
      end
    end
    if (ram_req.ren) begin
      ram_resp.rdata <= mem[idx];
    end
    ram_resp.rvalid <= ram_req.ren;
  end

endmodule

//--- rv_two_stage.sv
//////////////////////////////////////////////////////////////////////
// Two-stage RV32I subsystem
// Fetch and execute stages and a host port sharing one RAM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rv_two_stage #(
  parameter rv_core_pkg::word_t RESET_PC  = '0,
  parameter int                 RAM_WORDS = 1024
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  run,
  input  rv_mem_pkg::mem_req_t  host_req,
  output logic                  host_gnt,
  output rv_mem_pkg::mem_resp_t host_resp,
  output logic                  halt
);
  import rv_core_pkg::*;
  import rv_mem_pkg::*;

  mem_req_t  f_req, d_req, ram_req;
  mem_resp_t f_resp, d_resp, ram_resp;
  logic      f_gnt, d_gnt;
  fetch_ex_t fetch_ex;
  logic      brj_taken, ex_stall;
  word_t     brj_addr;

  fetch_stage #(.RESET_PC(RESET_PC)) fetch0 (
    .CLK(CLK), .rst_n(rst_n), .run(run),
    .f_req(f_req), .f_gnt(f_gnt), .f_resp(f_resp),
    .ex_stall(ex_stall), .brj_taken(brj_taken), .brj_addr(brj_addr),
    .halt(halt), .fetch_ex(fetch_ex)
  );

  execute_stage exec0 (
    .CLK(CLK), .rst_n(rst_n), .fetch_ex(fetch_ex),
    .d_req(d_req), .d_gnt(d_gnt), .d_resp(d_resp),
    .brj_taken(brj_taken), .brj_addr(brj_addr),
    .ex_stall(ex_stall), .halt(halt)
  );

  mem_arbiter arb0 (
    .CLK(CLK), .rst_n(rst_n),
    .d_req(d_req), .f_req(f_req), .host_req(host_req),
    .d_gnt(d_gnt), .f_gnt(f_gnt), .host_gnt(host_gnt),
    .d_resp(d_resp), .f_resp(f_resp), .host_resp(host_resp),
    .ram_req(ram_req), .ram_resp(ram_resp)
  );

  unified_ram #(.RAM_WORDS(RAM_WORDS)) ram0 (
    .CLK(CLK), .ram_req(ram_req), .ram_resp(ram_resp)
  );

endmodule

//--- tb_rv_two_stage.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the two-stage RV32I subsystem
// Loads hand-assembled programs over the host port, runs them to
// ECALL and checks memory contents against ISA arithmetic
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_rv_two_stage;
  import rv_mem_pkg::*;

  typedef enum logic [1:0] {
    HOST_WRITE,
    HOST_READ,
    RUN,
    RESET
  } tb_op_t;

  // One table row, test is the behavior number it belongs to
  typedef struct packed {
    tb_op_t      op;
    logic [3:0]  test;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  byte_en;
    logic [31:0] expected;
  } row_t;

  localparam int TIMEOUT = 2000;

  logic      CLK;
  logic      rst_n;
  logic      run;
  mem_req_t  host_req;
  logic      host_gnt;
  mem_resp_t host_resp;
  logic      halt;

  row_t  rows[$];
  int    pc_w;
  int    errors;
  int    test_errors;
  int    checks;
  int    tests_failed;
  logic  timed_out;
  string names[7];

  rv_two_stage #(.RESET_PC(32'h0), .RAM_WORDS(1024)) dut0 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .run       (run),
    .host_req  (host_req),
    .host_gnt  (host_gnt),
    .host_resp (host_resp),
    .halt      (halt)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  // RV32I instruction formats
  function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] stype(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] lui_word(int imm20, int rd);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] jal_word(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return itype(imm, rs1, 0, rd, 19);
  endfunction

  function automatic logic [31:0] load(int f3, int rd, int rs1, int imm);
    return itype(imm, rs1, f3, rd, 3);
  endfunction

  task automatic add_row(tb_op_t op, int test, logic [31:0] addr, logic [31:0] data,
                         logic [3:0] be, logic [31:0] exp);
    row_t r;
    r.op       = op;
    r.test     = test[3:0];
    r.addr     = addr;
    r.data     = data;
    r.byte_en  = be;
    r.expected = exp;
    rows.push_back(r);
  endtask

  // Program words go to consecutive addresses from 0
  task automatic emit(int test, logic [31:0] instr);
    add_row(HOST_WRITE, test, pc_w, instr, 4'hf, 32'h0);
    pc_w += 4;
  endtask

  task automatic build_table();
    int r2[13];
    logic [31:0] e2[13];
    int r3[13];
    logic [31:0] e3[13];
    // Host partial writes on two words
    add_row(HOST_WRITE, 1, 32'h300, 32'h11223344, 4'hf, 0);
    add_row(HOST_WRITE, 1, 32'h304, 32'hAABBCCDD, 4'hf, 0);
    add_row(HOST_WRITE, 1, 32'h300, 32'h000000EE, 4'b0001, 0);
    add_row(HOST_WRITE, 1, 32'h300, 32'h55000000, 4'b1000, 0);
    add_row(HOST_WRITE, 1, 32'h304, 32'h00009988, 4'b0011, 0);
    add_row(HOST_WRITE, 1, 32'h304, 32'h77660000, 4'b1100, 0);
    add_row(HOST_READ, 1, 32'h300, 0, 4'hf, 32'h552233EE);
    add_row(HOST_READ, 1, 32'h304, 0, 4'hf, 32'h77669988);

    // ALU program, x1 = 100, x2 = -7, shift amount 4
    pc_w = 0;
    emit(2, addi(10, 0, 32'h200));
    emit(2, addi(1, 0, 100));
    emit(2, addi(2, 0, -7));
    emit(2, rtype(0, 2, 1, 0, 3));
    emit(2, rtype(32, 2, 1, 0, 4));
    emit(2, rtype(0, 2, 1, 7, 5));
    emit(2, rtype(0, 2, 1, 6, 6));
    emit(2, rtype(0, 2, 1, 4, 7));
    emit(2, rtype(0, 1, 2, 2, 8));
    emit(2, rtype(0, 2, 1, 2, 9));
    emit(2, addi(11, 0, 4));
    emit(2, rtype(0, 11, 1, 1, 12));
    emit(2, rtype(0, 11, 2, 5, 13));
    emit(2, rtype(32, 11, 2, 5, 14));
    emit(2, lui_word(32'h12345, 15));
    r2 = '{3, 4, 5, 6, 7, 8, 9, 12, 13, 14, 15, 2, 1};
    e2 = '{32'h5D, 32'h6B, 32'h60, 32'hFFFFFFFD, 32'hFFFFFF9D, 32'h1, 32'h0,
           32'h640, 32'h0FFFFFFF, 32'hFFFFFFFF, 32'h12345000, 32'hFFFFFFF9, 32'h64};
    for (int k = 0; k < 13; k++) begin
      emit(2, stype(4 * k, r2[k], 10, 2));
    end
    emit(2, 32'h00000073);
    add_row(RUN, 2, 0, 0, 4'h0, 0);
    for (int k = 0; k < 13; k++) begin
      add_row(HOST_READ, 2, 32'h200 + 4 * k, 0, 4'hf, e2[k]);
    end

    // Loads from 0x380, bytes F3 A2 91 80 from low address up
    add_row(HOST_WRITE, 3, 32'h380, 32'h8091A2F3, 4'hf, 0);
    pc_w = 0;
    emit(3, addi(10, 0, 32'h380));
    emit(3, addi(11, 0, 32'h400));
    r3 = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 12, 13, 14, 15};
    for (int k = 0; k < 4; k++) begin
      emit(3, load(0, r3[k], 10, k));
      emit(3, load(4, r3[k + 4], 10, k));
    end
    emit(3, load(1, 9, 10, 0));
    emit(3, load(1, 12, 10, 2));
    emit(3, load(5, 13, 10, 0));
    emit(3, load(5, 14, 10, 2));
    emit(3, load(2, 15, 10, 0));
    e3 = '{32'hFFFFFFF3, 32'hFFFFFFA2, 32'hFFFFFF91, 32'hFFFFFF80, 32'hF3, 32'hA2,
           32'h91, 32'h80, 32'hFFFFA2F3, 32'hFFFF8091, 32'hA2F3, 32'h8091, 32'h8091A2F3};
    for (int k = 0; k < 13; k++) begin
      emit(3, stype(4 * k, r3[k], 11, 2));
    end
    emit(3, 32'h00000073);
    add_row(RUN, 3, 0, 0, 4'h0, 0);
    for (int k = 0; k < 13; k++) begin
      add_row(HOST_READ, 3, 32'h400 + 4 * k, 0, 4'hf, e3[k]);
    end

    // Byte and half stores of 0x12345678 into words of ones
    for (int k = 0; k < 6; k++) begin
      add_row(HOST_WRITE, 4, 32'h480 + 4 * k, 32'hFFFFFFFF, 4'hf, 0);
    end
    pc_w = 0;
    emit(4, addi(10, 0, 32'h480));
    emit(4, lui_word(32'h12345, 3));
    emit(4, addi(3, 3, 32'h678));
    emit(4, stype(0, 3, 10, 0));
    emit(4, stype(5, 3, 10, 0));
    emit(4, stype(10, 3, 10, 0));
    emit(4, stype(15, 3, 10, 0));
    emit(4, stype(16, 3, 10, 1));
    emit(4, stype(22, 3, 10, 1));
    emit(4, 32'h00000073);
    add_row(RUN, 4, 0, 0, 4'h0, 0);
    add_row(HOST_READ, 4, 32'h480, 0, 4'hf, 32'hFFFFFF78);
    add_row(HOST_READ, 4, 32'h484, 0, 4'hf, 32'hFFFF78FF);
    add_row(HOST_READ, 4, 32'h488, 0, 4'hf, 32'hFF78FFFF);
    add_row(HOST_READ, 4, 32'h48C, 0, 4'hf, 32'h78FFFFFF);
    add_row(HOST_READ, 4, 32'h490, 0, 4'hf, 32'hFFFF5678);
    add_row(HOST_READ, 4, 32'h494, 0, 4'hf, 32'h5678FFFF);

    // Branches and jumps, x5 is the good marker and x6 the bad one
    for (int k = 0; k < 12; k++) begin
      add_row(HOST_WRITE, 5, 32'h500 + 4 * k, 32'h0, 4'hf, 0);
    end
    pc_w = 0;
    emit(5, addi(10, 0, 32'h500));
    emit(5, addi(1, 0, 5));
    emit(5, addi(2, 0, 5));
    emit(5, addi(3, 0, -3));
    emit(5, addi(5, 0, 32'h11));
    emit(5, addi(6, 0, 32'h22));
    // Each pair is a taken case, then a not-taken case
    emit(5, stype(0, 5, 10, 2));
    emit(5, btype(8, 2, 1, 0));
    emit(5, stype(0, 6, 10, 2));
    emit(5, btype(8, 3, 1, 0));
    emit(5, stype(4, 5, 10, 2));
    emit(5, stype(8, 5, 10, 2));
    emit(5, btype(8, 3, 1, 1));
    emit(5, stype(8, 6, 10, 2));
    emit(5, btype(8, 2, 1, 1));
    emit(5, stype(12, 5, 10, 2));
    emit(5, stype(16, 5, 10, 2));
    emit(5, btype(8, 1, 3, 4));
    emit(5, stype(16, 6, 10, 2));
    emit(5, btype(8, 3, 1, 4));
    emit(5, stype(20, 5, 10, 2));
    emit(5, stype(24, 5, 10, 2));
    emit(5, btype(8, 3, 1, 5));
    emit(5, stype(24, 6, 10, 2));
    emit(5, btype(8, 1, 3, 5));
    emit(5, stype(28, 5, 10, 2));
    // JAL at 104 and JALR at 116 to absolute 124
    emit(5, jal_word(8, 8));
    emit(5, stype(32, 6, 10, 2));
    emit(5, stype(36, 8, 10, 2));
    emit(5, itype(124, 0, 0, 9, 103));
    emit(5, stype(40, 6, 10, 2));
    emit(5, stype(44, 9, 10, 2));
    emit(5, 32'h00000073);
    add_row(RUN, 5, 0, 0, 4'h0, 0);
    for (int k = 0; k < 8; k++) begin
      add_row(HOST_READ, 5, 32'h500 + 4 * k, 0, 4'hf, 32'h11);
    end
    add_row(HOST_READ, 5, 32'h520, 0, 4'hf, 32'h0);
    add_row(HOST_READ, 5, 32'h524, 0, 4'hf, 32'd108);
    add_row(HOST_READ, 5, 32'h528, 0, 4'hf, 32'h0);
    add_row(HOST_READ, 5, 32'h52C, 0, 4'hf, 32'd120);

    // Store before ECALL lands, store after ECALL must never land
    add_row(HOST_WRITE, 6, 32'h600, 32'h0, 4'hf, 0);
    add_row(HOST_WRITE, 6, 32'h604, 32'h0, 4'hf, 0);
    pc_w = 0;
    emit(6, addi(10, 0, 32'h600));
    emit(6, addi(1, 0, 32'h33));
    emit(6, stype(0, 1, 10, 2));
    emit(6, 32'h00000073);
    emit(6, stype(4, 1, 10, 2));
    add_row(RUN, 6, 0, 0, 4'h0, 0);
    add_row(HOST_READ, 6, 32'h600, 0, 4'hf, 32'h33);
    add_row(HOST_READ, 6, 32'h604, 0, 4'hf, 32'h0);
    add_row(RESET, 6, 0, 0, 4'h0, 0);
  endtask

  // A timeout ends the table walk and fails the current test
  task automatic report_timeout(string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    timed_out = 1'b1;
    test_errors++;
  endtask

  task automatic wait_host_gnt();
    int n;
    n = 0;
    @(negedge CLK);
    while (!host_gnt && n < TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (!host_gnt) report_timeout("host grant");
  endtask

  task automatic host_access(row_t r, logic is_read);
    int n;
    @(posedge CLK);
    host_req <= '{ren: is_read, wen: ~is_read, addr: r.addr, wdata: r.data,
                  byte_en: r.byte_en};
    wait_host_gnt();
    @(posedge CLK);
    host_req <= '0;
    if (is_read && !timed_out) begin
      n = 0;
      @(negedge CLK);
      while (!host_resp.rvalid && n < TIMEOUT) begin
        @(negedge CLK);
        n++;
      end
      if (!host_resp.rvalid) begin
        report_timeout("host read data");
      end else begin
        checks++;
        assert (host_resp.rdata === r.expected) else begin
          $display("** Error at %0t: host_resp.rdata (addr %h) = %h, expected %h",
                   $time, r.addr, host_resp.rdata, r.expected);
          test_errors++;
        end
      end
    end
  endtask

  // Two-cycle reset with run low, halt must come out low
  task automatic reset_core();
    @(posedge CLK);
    rst_n <= 1'b0;
    run   <= 1'b0;
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);
    checks++;
    assert (halt === 1'b0) else begin
      $display("** Error at %0t: halt = %b, expected %b", $time, halt, 1'b0);
      test_errors++;
    end
  endtask

  task automatic run_program();
    int n;
    reset_core();
    @(posedge CLK);
    run <= 1'b1;
    n = 0;
    @(negedge CLK);
    while (!halt && n < TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (!halt) begin
      report_timeout("halt after ECALL");
    end else begin
      // Halt is sticky while run stays high
      repeat (20) begin
        @(negedge CLK);
        checks++;
        assert (halt === 1'b1) else begin
          $display("** Error at %0t: halt = %b, expected %b", $time, halt, 1'b1);
          test_errors++;
        end
      end
    end
    @(posedge CLK);
    run <= 1'b0;
  endtask

  initial begin
    rst_n        = 1'b0;
    run          = 1'b0;
    host_req     = '0;
    errors       = 0;
    test_errors  = 0;
    checks       = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    names = '{"", "host port", "ALU", "loads", "stores", "control flow", "halt and reset"};
    build_table();
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      case (rows[i].op)
        HOST_WRITE: host_access(rows[i], 1'b0);
        HOST_READ:  host_access(rows[i], 1'b1);
        RUN:        run_program();
        default:    reset_core();
      endcase
      // Last row of a test closes it
      if (timed_out || i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
        $display("test %0d (%s): %s, %0d errors", rows[i].test, names[rows[i].test],
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        if (test_errors != 0) tests_failed++;
        errors      += test_errors;
        test_errors  = 0;
      end
    end

    $display("tests: 6, failed: %0d, checks: %0d, errors: %0d", tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- rv_two_stage.f
rv_core_pkg.sv
rv_mem_pkg.sv
control_unit.sv
rv_reg_file.sv
fetch_stage.sv
execute_stage.sv
mem_arbiter.sv
unified_ram.sv
rv_two_stage.sv
tb_rv_two_stage.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f rv_two_stage.f \
		--top-module tb_rv_two_stage -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
